// ==== verilog/host_pkg.sv ====
package host_pkg;

  // One SPI frame carries one full word in each direction
  typedef logic [63:0] host_word_t;

  // Command codes found in the top byte of a header word
  typedef enum logic [7:0] {
    CMD_MOVE      = 8'h01,
    CMD_DIVISOR   = 8'h03,
    CMD_MICROSTEP = 8'h04,
    CMD_VERSION   = 8'hFE
  } cmd_code_e;

  // Header layout, code in the MSB byte
  typedef struct packed {
    logic [7:0]  code;
    logic [55:0] payload;  // Move dir in bit 0, divisor or ustep in the low bits
  } host_header_t;

  // Same received word, read as a header or as raw move data
  typedef union packed {
    host_header_t hdr;
    host_word_t   raw;
  } host_rx_u;

  // API version returned for CMD_VERSION
  localparam logic [7:0] VERSION_MAJOR = 8'd1;
  localparam logic [7:0] VERSION_MINOR = 8'd2;
  localparam logic [7:0] VERSION_PATCH = 8'd0;

endpackage

// ==== verilog/motion_pkg.sv ====
package motion_pkg;

  typedef logic [23:0] divisor_t;  // CLK cycles per DDA tick
  typedef logic [1:0]  ustep_t;    // log2 of microsteps per full step

  // Parameters of one coordinated move
  typedef struct packed {
    logic               dir;
    logic [63:0]        duration;   // In ticks
    logic signed [63:0] increment;  // Initial velocity term
    logic signed [63:0] incr_step;  // Added to increment every tick after the first
  } move_cmd_t;

  // Results of the most recent move
  typedef struct packed {
    logic [63:0]        ticks;
    logic [63:0]        steps;
    logic signed [63:0] enc_snapshot;  // Encoder count at the last tick
  } move_stats_t;

  // Removed from the accumulator on every step, close to the int64 max
  localparam logic signed [63:0] STEP_THRESHOLD = 64'sh7FFF_FFFF_FFFF_FF9B;

endpackage

// ==== verilog/spi_word_rx.sv ====
module spi_word_rx import host_pkg::*; (
  input  logic       CLK,
  input  logic       rst_n,
  input  logic       sck,
  input  logic       cs_n,
  input  logic       copi,
  output logic       cipo,
  input  host_word_t tx_word,
  output host_word_t rx_word,
  output logic       rx_valid
);

  logic [2:0] sck_q;  // Two sync stages plus one history stage
  logic [2:0] cs_q;
  logic [1:0] copi_q;  // Same depth as sck_q[1], keeps data aligned to the edge
  logic       sck_rise;
  logic       sck_fall;
  logic       frame_start;
  logic       in_frame;
  logic [6:0] bit_cnt;
  host_word_t rx_shift;
  host_word_t tx_shift;

  assign sck_rise    = sck_q[1] & ~sck_q[2];
  assign sck_fall    = ~sck_q[1] & sck_q[2];
  assign frame_start = ~cs_q[1] & cs_q[2];
  assign in_frame    = ~cs_q[1];
  assign cipo        = tx_shift[63];  // MSB first

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      sck_q  <= '0;
      cs_q   <= '1;  // Bus idles deselected
      copi_q <= '0;
    end else begin
      sck_q  <= {sck_q[1:0], sck};
      cs_q   <= {cs_q[1:0], cs_n};
      copi_q <= {copi_q[0], copi};
    end
  end

  // Bit counting and reply shifting
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      bit_cnt  <= '0;
      rx_valid <= 1'b0;
      tx_shift <= '0;
    end else begin
      rx_valid <= 1'b0;
      if (!in_frame) begin
        bit_cnt <= '0;  // Short frames are simply forgotten
      end else if (sck_rise) begin
        bit_cnt  <= bit_cnt + 7'd1;
        rx_valid <= (bit_cnt == 7'd63);
      end

      if (frame_start) begin
        tx_shift <= tx_word;
      end else if (in_frame && sck_fall) begin
        tx_shift <= {tx_shift[62:0], 1'b0};
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (in_frame && sck_rise) begin
      rx_shift <= {rx_shift[62:0], copi_q[1]};
      if (bit_cnt == 7'd63) begin
        rx_word <= {rx_shift[62:0], copi_q[1]};
      end
    end
  end

  // Host must deassert CS after each 64-bit word
  a_frame_len: assert property (@(posedge CLK) disable iff (!rst_n) bit_cnt <= 7'd64)
    else $error("SPI frame longer than 64 bits");

endmodule

// ==== verilog/cmd_decoder.sv ====
module cmd_decoder import host_pkg::*, motion_pkg::*; #(
  parameter divisor_t DEFAULT_DIVISOR = 24'd40
) (
  input  logic               CLK,
  input  logic               rst_n,
  input  host_word_t         rx_word,
  input  logic               rx_valid,
  input  logic signed [63:0] enc_count,
  input  logic               busy,
  input  move_stats_t        stats,
  output host_word_t         tx_word,
  output move_cmd_t          move_cmd,
  output logic               move_start,
  output divisor_t           divisor,
  output ustep_t             ustep,
  output logic               led
);

  typedef enum logic [2:0] {
    ST_HEADER,
    ST_MOVE1,
    ST_MOVE2,
    ST_MOVE3,
    ST_DISCARD
  } state_e;

  // Which word goes out in the next frame
  typedef enum logic [2:0] {
    RPL_ENC,
    RPL_TICKS,
    RPL_STEPS,
    RPL_SNAP,
    RPL_VERSION
  } reply_e;

  state_e   state;
  reply_e   reply_sel;
  host_rx_u rx_u;

  assign rx_u.raw = rx_word;

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      state      <= ST_HEADER;
      reply_sel  <= RPL_ENC;
      divisor    <= DEFAULT_DIVISOR;
      ustep      <= '0;
      move_start <= 1'b0;
      led        <= 1'b0;
    end else begin
      move_start <= 1'b0;
      if (rx_valid) begin
        led       <= ~led;  // Activity blink per word
        reply_sel <= RPL_ENC;
        case (state)
          ST_HEADER: begin
            case (rx_u.hdr.code)
              CMD_MOVE: begin
                reply_sel <= RPL_TICKS;
                state     <= ST_MOVE1;
              end
              CMD_DIVISOR: begin
                if (rx_u.hdr.payload[23:0] != 24'd0) begin
                  divisor <= rx_u.hdr.payload[23:0];
                end
              end
              CMD_MICROSTEP: ustep <= rx_u.hdr.payload[1:0];
              CMD_VERSION: begin
                reply_sel <= RPL_VERSION;
                state     <= ST_DISCARD;  // Word carrying the version back is a dummy
              end
              default: ;  // Unknown codes ignored
            endcase
          end
          ST_MOVE1: begin
            reply_sel <= RPL_STEPS;
            state     <= ST_MOVE2;
          end
          ST_MOVE2: begin
            reply_sel <= RPL_SNAP;
            state     <= ST_MOVE3;
          end
          ST_MOVE3: begin
            move_start <= ~busy;  // No queue, late moves are lost
            state      <= ST_HEADER;
          end
          default: state <= ST_HEADER;
        endcase
      end
    end
  end

  // Move words are captured as raw data
  always_ff @(posedge CLK) begin
    if (rx_valid) begin
      case (state)
        ST_HEADER: begin
          if (rx_u.hdr.code == CMD_MOVE) begin
            move_cmd.dir <= rx_u.hdr.payload[0];
          end
        end
        ST_MOVE1: move_cmd.duration  <= rx_u.raw;
        ST_MOVE2: move_cmd.increment <= rx_u.raw;
        ST_MOVE3: move_cmd.incr_step <= rx_u.raw;
        default: ;
      endcase
    end
  end

  always_comb begin
    case (reply_sel)
      RPL_TICKS:   tx_word = stats.ticks;
      RPL_STEPS:   tx_word = stats.steps;
      RPL_SNAP:    tx_word = stats.enc_snapshot;
      RPL_VERSION: tx_word = {40'd0, VERSION_MAJOR, VERSION_MINOR, VERSION_PATCH};
      default:     tx_word = enc_count;  // Live encoder position
    endcase
  end

  // A start must never land on a running move
  a_no_start_busy: assert property (@(posedge CLK) disable iff (!rst_n) move_start |-> !busy)
    else $error("move_start while profile busy");

endmodule

// ==== verilog/move_profile.sv ====
module move_profile import motion_pkg::*; (
  input  logic               CLK,
  input  logic               rst_n,
  input  move_cmd_t          move_cmd,
  input  logic               move_start,
  input  divisor_t           divisor,
  input  logic signed [63:0] enc_count,
  output logic               busy,
  output logic               step_pulse,
  output logic               dir,
  output move_stats_t        stats
);

  move_cmd_t          cmd_q;  // Held for the whole move
  divisor_t           clk_cnt;
  logic signed [63:0] incr_r;
  logic signed [63:0] acc;
  logic signed [63:0] incr_next;
  logic signed [63:0] acc_sum;
  logic               done;
  logic               tick;

  assign done      = stats.ticks >= cmd_q.duration;
  assign tick      = busy && !done && (clk_cnt >= divisor - 24'd1);
  // Second order term, first tick loads the start increment
  assign incr_next = (stats.ticks == 64'd0) ? cmd_q.increment : incr_r + cmd_q.incr_step;
  assign acc_sum   = acc + incr_next;
  assign dir       = cmd_q.dir;

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      cmd_q      <= '0;
      busy       <= 1'b0;
      step_pulse <= 1'b0;
      clk_cnt    <= '0;
      incr_r     <= '0;
      acc        <= '0;
      stats      <= '0;
    end else begin
      step_pulse <= 1'b0;
      if (move_start && !busy) begin
        cmd_q       <= move_cmd;
        busy        <= 1'b1;
        clk_cnt     <= '0;
        acc         <= '0;
        stats.ticks <= '0;
        stats.steps <= '0;
      end else if (busy) begin
        if (done) begin
          busy <= 1'b0;
        end else if (tick) begin
          clk_cnt            <= '0;
          incr_r             <= incr_next;
          stats.ticks        <= stats.ticks + 64'd1;
          stats.enc_snapshot <= enc_count;
          if (acc_sum > 0) begin
            step_pulse  <= 1'b1;
            stats.steps <= stats.steps + 64'd1;
            acc         <= acc_sum - STEP_THRESHOLD;
          end else begin
            acc <= acc_sum;
          end
        end else begin
          clk_cnt <= clk_cnt + 24'd1;
        end
      end
    end
  end

  // Steps only come out of a running move
  a_step_in_move: assert property (@(posedge CLK) disable iff (!rst_n) step_pulse |-> busy)
    else $error("step pulse outside a move");

endmodule

// ==== verilog/phase_driver.sv ====
module phase_driver import motion_pkg::*; #(
  parameter int PWM_BITS = 4
) (
  input  logic   CLK,
  input  logic   rst_n,
  input  logic   step_pulse,
  input  logic   dir,
  input  ustep_t ustep,
  output logic   phase_a1,
  output logic   phase_a2,
  output logic   phase_b1,
  output logic   phase_b2
);

  typedef struct packed {
    logic              neg;   // Current flows 2 to 1
    logic [PWM_BITS:0] duty;  // 2**PWM_BITS is fully on
  } coil_t;

  logic [4:0]          pos;  // 32 positions per electrical turn
  logic [4:0]          pos_a;
  logic [4:0]          pos_delta;
  logic [PWM_BITS-1:0] pwm_cnt;
  coil_t               coil_a;
  coil_t               coil_b;

  // sin(idx * pi/16) for idx 0..8, scaled to the PWM range
  function automatic logic [PWM_BITS:0] quarter_sine(input logic [3:0] idx);
    int q8;
    case (idx)
      4'd0:    q8 = 0;
      4'd1:    q8 = 50;
      4'd2:    q8 = 98;
      4'd3:    q8 = 142;
      4'd4:    q8 = 181;
      4'd5:    q8 = 213;
      4'd6:    q8 = 237;
      4'd7:    q8 = 251;
      default: q8 = 256;
    endcase
    return (PWM_BITS + 1)'(((q8 << PWM_BITS) + 128) >> 8);
  endfunction

  function automatic coil_t coil_drive(input logic [4:0] p);
    coil_t c;
    c.neg  = p[4];  // Second half of the turn
    c.duty = p[3] ? quarter_sine(4'd8 - {1'b0, p[2:0]}) : quarter_sine({1'b0, p[2:0]});
    return c;
  endfunction

  assign pos_delta = 5'd8 >> ustep;
  assign pos_a     = pos + 5'd8;  // Coil A leads by a quarter turn
  assign coil_a    = coil_drive(pos_a);
  assign coil_b    = coil_drive(pos);

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      pos      <= '0;
      pwm_cnt  <= '0;
      phase_a1 <= 1'b0;
      phase_a2 <= 1'b0;
      phase_b1 <= 1'b0;
      phase_b2 <= 1'b0;
    end else begin
      pwm_cnt <= pwm_cnt + 1'b1;
      if (step_pulse) begin
        pos <= dir ? pos + pos_delta : pos - pos_delta;
      end
      phase_a1 <= !coil_a.neg && ({1'b0, pwm_cnt} < coil_a.duty);
      phase_a2 <= coil_a.neg && ({1'b0, pwm_cnt} < coil_a.duty);
      phase_b1 <= !coil_b.neg && ({1'b0, pwm_cnt} < coil_b.duty);
      phase_b2 <= coil_b.neg && ({1'b0, pwm_cnt} < coil_b.duty);
    end
  end

endmodule

// ==== verilog/quad_counter.sv ====
module quad_counter (
  input  logic               CLK,
  input  logic               rst_n,
  input  logic               enc_a,
  input  logic               enc_b,
  output logic signed [63:0] count,
  output logic               fault
);

  logic [1:0] ab_s1;
  logic [1:0] ab_s2;    // Synchronised {a, b}
  logic [1:0] ab_prev;

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      ab_s1   <= '0;
      ab_s2   <= '0;
      ab_prev <= '0;
      count   <= '0;
      fault   <= 1'b0;
    end else begin
      ab_s1   <= {enc_a, enc_b};
      ab_s2   <= ab_s1;
      ab_prev <= ab_s2;
      case ({ab_prev, ab_s2})
        // Forward Gray order 00 01 11 10
        4'b00_01, 4'b01_11, 4'b11_10, 4'b10_00: count <= count + 64'sd1;
        4'b01_00, 4'b11_01, 4'b10_11, 4'b00_10: count <= count - 64'sd1;
        // Both lines moved at once, position lost
        4'b00_11, 4'b11_00, 4'b01_10, 4'b10_01: fault <= 1'b1;
        default: ;  // No change
      endcase
    end
  end

endmodule

// ==== verilog/stepper_ctrl_top.sv ====
module stepper_ctrl_top import host_pkg::*, motion_pkg::*; #(
  parameter divisor_t DEFAULT_DIVISOR = 24'd40,
  parameter int       PWM_BITS        = 4
) (
  input  logic CLK,
  input  logic rst_n,
  input  logic sck,
  input  logic cs_n,
  input  logic copi,
  output logic cipo,
  input  logic enc_a,
  input  logic enc_b,
  output logic phase_a1,
  output logic phase_a2,
  output logic phase_b1,
  output logic phase_b2,
  output logic step,
  output logic dir,
  output logic busy,
  output logic enc_fault,
  output logic led
);

  host_word_t         rx_word;
  host_word_t         tx_word;
  logic               rx_valid;
  move_cmd_t          move_cmd;
  logic               move_start;
  divisor_t           divisor;
  ustep_t             ustep;
  move_stats_t        stats;
  logic signed [63:0] enc_count;

  spi_word_rx u_spi (
    .CLK      (CLK),
    .rst_n    (rst_n),
    .sck      (sck),
    .cs_n     (cs_n),
    .copi     (copi),
    .cipo     (cipo),
    .tx_word  (tx_word),
    .rx_word  (rx_word),
    .rx_valid (rx_valid)
  );

  cmd_decoder #(
    .DEFAULT_DIVISOR (DEFAULT_DIVISOR)
  ) u_decoder (
    .CLK        (CLK),
    .rst_n      (rst_n),
    .rx_word    (rx_word),
    .rx_valid   (rx_valid),
    .enc_count  (enc_count),
    .busy       (busy),
    .stats      (stats),
    .tx_word    (tx_word),
    .move_cmd   (move_cmd),
    .move_start (move_start),
    .divisor    (divisor),
    .ustep      (ustep),
    .led        (led)
  );

  move_profile u_profile (
    .CLK        (CLK),
    .rst_n      (rst_n),
    .move_cmd   (move_cmd),
    .move_start (move_start),
    .divisor    (divisor),
    .enc_count  (enc_count),
    .busy       (busy),
    .step_pulse (step),
    .dir        (dir),
    .stats      (stats)
  );

  phase_driver #(
    .PWM_BITS (PWM_BITS)
  ) u_phase (
    .CLK        (CLK),
    .rst_n      (rst_n),
    .step_pulse (step),
    .dir        (dir),
    .ustep      (ustep),
    .phase_a1   (phase_a1),
    .phase_a2   (phase_a2),
    .phase_b1   (phase_b1),
    .phase_b2   (phase_b2)
  );

  quad_counter u_encoder (
    .CLK   (CLK),
    .rst_n (rst_n),
    .enc_a (enc_a),
    .enc_b (enc_b),
    .count (enc_count),
    .fault (enc_fault)
  );

endmodule

// ==== tb/tb_stepper_ctrl.sv ====
module tb_stepper_ctrl import host_pkg::*, motion_pkg::*; ();

  localparam int         SCK_HALF     = 8;  // CLK cycles per SCK half period
  localparam int         FRAME_CYCLES = (2 * 64 + 3) * SCK_HALF;
  localparam int         ENC_HOLD     = 4;  // Cycles each encoder state is held
  localparam int         LONG_TICKS   = 2000;
  localparam int         IDLE_LIMIT   = LONG_TICKS * 3 + 50;
  localparam host_word_t NOP_WORD     = '0;  // Code 0x00 is ignored by the decoder

  // Worst case length of each test in CLK cycles
  localparam int RESET_CYCLES    = 5;
  localparam int VERSION_CYCLES  = 3 * FRAME_CYCLES;
  localparam int ENCODER_CYCLES  = FRAME_CYCLES + 50 * (ENC_HOLD + 1) + 30;
  localparam int MOVE_CYCLES     = 10 * FRAME_CYCLES + 2 * (24 * 3 + 6);
  localparam int USTEP_CYCLES    = 18 * FRAME_CYCLES + 4 * (3 * 3 + 6 + 16);
  localparam int DROP_CYCLES     = 17 * FRAME_CYCLES + LONG_TICKS * 3 + 30 + 2 * (20 * 3 + 6);
  localparam int WATCHDOG_CYCLES = 2 * (RESET_CYCLES + VERSION_CYCLES + ENCODER_CYCLES +
                                        MOVE_CYCLES + USTEP_CYCLES + DROP_CYCLES);

  logic CLK;
  logic rst_n;
  logic sck;
  logic cs_n;
  logic copi;
  logic cipo;
  logic enc_a;
  logic enc_b;
  logic phase_a1;
  logic phase_a2;
  logic phase_b1;
  logic phase_b2;
  logic step;
  logic dir;
  logic busy;
  logic enc_fault;
  logic led;

  longint      step_count  = 0;
  longint      busy_count  = 0;
  logic [4:0]  elec_pos    = '0;  // Expected electrical position out of 32
  int          cur_ustep   = 0;
  int          enc_pos     = 0;
  int          enc_idx     = 0;
  int          words_sent  = 0;
  int unsigned seed_val;

  stepper_ctrl_top u_dut (
    .CLK       (CLK),
    .rst_n     (rst_n),
    .sck       (sck),
    .cs_n      (cs_n),
    .copi      (copi),
    .cipo      (cipo),
    .enc_a     (enc_a),
    .enc_b     (enc_b),
    .phase_a1  (phase_a1),
    .phase_a2  (phase_a2),
    .phase_b1  (phase_b1),
    .phase_b2  (phase_b2),
    .step      (step),
    .dir       (dir),
    .busy      (busy),
    .enc_fault (enc_fault),
    .led       (led)
  );

  initial begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;
  end

  // Step and busy bookkeeping
  always @(negedge CLK) begin
    if (busy) busy_count++;
    if (step) step_count++;
  end

  task automatic stop_failed();
    $display("RESULT: FAIL");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      $display("MISMATCH %s: expected %0h, actual %0h", name, exp, act);
      stop_failed();
    end
  endtask

  function automatic host_word_t header_word(input cmd_code_e code, input logic [55:0] payload);
    host_header_t h;
    h.code    = code;
    h.payload = payload;
    return h;
  endfunction

  function automatic move_cmd_t make_move(input logic mdir, input logic [63:0] duration,
                                          input logic signed [63:0] increment,
                                          input logic signed [63:0] incr_step);
    move_cmd_t m;
    m.dir       = mdir;
    m.duration  = duration;
    m.increment = increment;
    m.incr_step = incr_step;
    return m;
  endfunction

  // Second order reference DDA with one pass per tick
  function automatic logic [63:0] dda_steps(input move_cmd_t m);
    logic signed [63:0] acc;
    logic signed [63:0] incr;
    logic [63:0]        steps;
    logic [63:0]        t;
    acc   = '0;
    incr  = '0;
    steps = '0;
    for (t = 0; t < m.duration; t++) begin
      incr = (t == 0) ? m.increment : incr + m.incr_step;
      acc  = acc + incr;
      if (acc > 0) begin
        steps++;
        acc = acc - STEP_THRESHOLD;
      end
    end
    return steps;
  endfunction

  // Coil pins {a1, a2, b1, b2} for wave states A+, B+, A-, B-
  function automatic logic [3:0] wave_pattern(input logic [1:0] state);
    case (state)
      2'd0:    return 4'b1000;
      2'd1:    return 4'b0010;
      2'd2:    return 4'b0100;
      default: return 4'b0001;
    endcase
  endfunction

  // Commanded steps move the expected rotor position
  task automatic advance_pos(input logic mdir, input longint n);
    logic [4:0] delta;
    delta    = 5'(n * (8 >> cur_ustep));
    elec_pos = mdir ? elec_pos + delta : elec_pos - delta;
  endtask

  // One 64-bit word each way in SPI mode 0 with MSB first
  task automatic spi_xfer(input host_word_t send, output host_word_t reply);
    reply = '0;
    @(negedge CLK);
    cs_n = 1'b0;
    for (int i = 63; i >= 0; i--) begin
      copi = send[i];
      repeat (SCK_HALF) @(negedge CLK);
      reply[i] = cipo;  // Stable since the last falling SCK
      sck = 1'b1;
      repeat (SCK_HALF) @(negedge CLK);
      sck = 1'b0;
    end
    repeat (SCK_HALF) @(negedge CLK);
    cs_n = 1'b1;
    repeat (SCK_HALF) @(negedge CLK);  // Gap before the next frame
    words_sent++;
  endtask

  task automatic send_cmd(input cmd_code_e code, input logic [55:0] payload);
    host_word_t r;
    spi_xfer(header_word(code, payload), r);
  endtask

  task automatic set_ustep(input int value);
    send_cmd(CMD_MICROSTEP, 56'(value));
    cur_ustep = value;
  endtask

  // Replies of the data frames carry the previous move's results
  task automatic move_xfer(input move_cmd_t m, output move_stats_t rep);
    host_word_t r;
    spi_xfer(header_word(CMD_MOVE, {55'd0, m.dir}), r);
    spi_xfer(m.duration, rep.ticks);
    spi_xfer(m.increment, rep.steps);
    spi_xfer(m.incr_step, rep.enc_snapshot);
  endtask

  task automatic wait_idle(input int limit);
    int waited;
    waited = 0;
    while (busy) begin
      @(negedge CLK);
      waited++;
      if (waited > limit) begin
        $display("ERROR: move still busy after %0d cycles", limit);
        stop_failed();
      end
    end
    repeat (4) @(negedge CLK);  // Step and coil outputs settle
  endtask

  task automatic run_move(input move_cmd_t m, output move_stats_t rep,
                          output longint steps, output longint cycles);
    longint steps0;
    longint busy0;
    steps0 = step_count;
    busy0  = busy_count;
    move_xfer(m, rep);
    wait_idle(IDLE_LIMIT);
    steps  = step_count - steps0;
    cycles = busy_count - busy0;
  endtask

  task automatic enc_steps(input int n, input bit fwd);
    logic [1:0] gray [4];
    gray = '{2'b00, 2'b01, 2'b11, 2'b10};
    for (int i = 0; i < n; i++) begin
      @(negedge CLK);
      enc_idx = fwd ? (enc_idx + 1) % 4 : (enc_idx + 3) % 4;
      enc_pos = fwd ? enc_pos + 1 : enc_pos - 1;
      {enc_a, enc_b} = gray[enc_idx];
      repeat (ENC_HOLD) @(negedge CLK);
    end
  endtask

  task automatic check_coils(input string name);
    repeat (16) begin  // One full PWM period
      @(negedge CLK);
      check(name, 64'(wave_pattern(elec_pos[4:3])), 64'({phase_a1, phase_a2, phase_b1, phase_b2}));
    end
  endtask

  task automatic version_readback();
    host_word_t r;
    host_word_t ver;
    ver = {40'd0, VERSION_MAJOR, VERSION_MINOR, VERSION_PATCH};
    send_cmd(CMD_VERSION, '0);
    spi_xfer(NOP_WORD, r);
    check("version word", ver, r);
    spi_xfer(NOP_WORD, r);
    check("encoder reply after version", 64'(enc_pos), r);
    check("led parity", 64'(words_sent % 2), 64'(led));
  endtask

  task automatic encoder_count();
    host_word_t r;
    enc_steps(37, 1'b1);
    enc_steps(12, 1'b0);
    spi_xfer(NOP_WORD, r);
    check("encoder count", 64'd25, r);
    check("fault before glitch", 64'd0, 64'(enc_fault));
    @(negedge CLK);
    {enc_a, enc_b} = ~{enc_a, enc_b};  // Both lines at once
    repeat (ENC_HOLD) @(negedge CLK);
    check("fault after glitch", 64'd1, 64'(enc_fault));
    repeat (20) @(negedge CLK);
    check("fault sticky", 64'd1, 64'(enc_fault));
  endtask

  task automatic random_move();
    move_cmd_t   m;
    move_stats_t rep;
    logic [63:0] span;
    logic [63:0] exp_steps;
    longint      steps;
    longint      cycles;
    send_cmd(CMD_DIVISOR, 56'd3);
    set_ustep(0);
    span        = 64'(STEP_THRESHOLD >>> 2);
    m.dir       = 1'($urandom % 2);
    m.duration  = 64'(4 + $urandom % 21);
    m.increment = (STEP_THRESHOLD >>> 3) + $signed({$urandom, $urandom} % span);
    m.incr_step = $signed(64'($urandom) << 24);
    exp_steps   = dda_steps(m);
    run_move(m, rep, steps, cycles);
    advance_pos(m.dir, longint'(exp_steps));
    check("move step count", exp_steps, 64'(steps));
    check("move dir", 64'(m.dir), 64'(dir));
    check("move busy cycles", m.duration * 3 + 1, 64'(cycles));
    // Zero length move only reads back the stats
    run_move(make_move(m.dir, '0, '0, '0), rep, steps, cycles);
    check("zero move busy cycles", 64'd1, 64'(cycles));
    check("stats ticks", m.duration, rep.ticks);
    check("stats steps", exp_steps, rep.steps);
    check("stats encoder snapshot", 64'(enc_pos), rep.enc_snapshot);
  endtask

  task automatic microstep_pattern();
    move_stats_t rep;
    longint      steps;
    longint      cycles;
    set_ustep(0);
    for (int k = 1; k <= 3; k++) begin
      run_move(make_move(1'b1, 64'(k), STEP_THRESHOLD, '0), rep, steps, cycles);
      advance_pos(1'b1, k);
      check("full step count", 64'(k), 64'(steps));
      check_coils("full step coil pattern");
    end
    set_ustep(1);
    run_move(make_move(1'b1, 64'd2, STEP_THRESHOLD, '0), rep, steps, cycles);
    advance_pos(1'b1, 2);
    check("half step count", 64'd2, 64'(steps));
    check_coils("half step coil pattern");
  endtask

  task automatic drop_and_divisor();
    move_stats_t rep;
    longint      steps0;
    longint      steps1;
    longint      steps2;
    longint      cycles1;
    longint      cycles2;
    steps0 = step_count;
    move_xfer(make_move(1'b1, 64'(LONG_TICKS), STEP_THRESHOLD, '0), rep);
    check("busy on long move", 64'd1, 64'(busy));
    move_xfer(make_move(1'b0, 64'd50, STEP_THRESHOLD, '0), rep);
    check("busy when second move arrives", 64'd1, 64'(busy));
    wait_idle(IDLE_LIMIT);
    repeat (20) @(negedge CLK);
    check("dropped move never starts", 64'd0, 64'(busy));
    check("steps with dropped move", 64'(LONG_TICKS), 64'(step_count - steps0));
    run_move(make_move(1'b1, 64'd20, STEP_THRESHOLD, '0), rep, steps1, cycles1);
    check("busy cycles at divisor 3", 64'd61, 64'(cycles1));
    send_cmd(CMD_DIVISOR, 56'd0);
    run_move(make_move(1'b1, 64'd20, STEP_THRESHOLD, '0), rep, steps2, cycles2);
    check("busy cycles after divisor 0", 64'(cycles1), 64'(cycles2));
    check("steps after divisor 0", 64'(steps1), 64'(steps2));
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge CLK);
    $display("ERROR: watchdog expired after %0d cycles, tests did not finish", WATCHDOG_CYCLES);
    stop_failed();
  end

  initial begin
    seed_val = $urandom(32'he13ebbc6);
    rst_n    = 1'b0;
    sck      = 1'b0;
    cs_n     = 1'b1;
    copi     = 1'b0;
    enc_a    = 1'b0;
    enc_b    = 1'b0;
    repeat (RESET_CYCLES) @(negedge CLK);
    rst_n = 1'b1;
    @(negedge CLK);
    check("step after reset", 64'd0, 64'(step));
    check("busy after reset", 64'd0, 64'(busy));
    check("fault after reset", 64'd0, 64'(enc_fault));
    check("led after reset", 64'd0, 64'(led));

    version_readback();
    encoder_count();
    random_move();
    microstep_pattern();
    drop_and_divisor();
    check("fault still set at end", 64'd1, 64'(enc_fault));

    $display("RESULT: PASS");
    $finish;
  end

endmodule

// ==== sources.f ====
verilog/host_pkg.sv
verilog/motion_pkg.sv
verilog/spi_word_rx.sv
verilog/cmd_decoder.sv
verilog/move_profile.sv
verilog/phase_driver.sv
verilog/quad_counter.sv
verilog/stepper_ctrl_top.sv
tb/tb_stepper_ctrl.sv

// ==== Bender.yml ====
package:
  name: stepper_ctrl

sources:
  - verilog/host_pkg.sv
  - verilog/motion_pkg.sv
  - verilog/spi_word_rx.sv
  - verilog/cmd_decoder.sv
  - verilog/move_profile.sv
  - verilog/phase_driver.sv
  - verilog/quad_counter.sv
  - verilog/stepper_ctrl_top.sv
  - target: simulation
    files:
      - tb/tb_stepper_ctrl.sv
